//--- Bender.yml
package:
  name: sd_read

export_include_dirs:
  - .

sources:
  - files:
      - sd_dat_pkg.sv
      - dat_block_sequencer.sv
      - dat_lane_crc.sv
      - dat_bus_driver.sv
      - sd_read_top.sv
  - target: test
    files:
      - sd_read_properties.sv
      - tb_sd_read.sv

//--- dat_block_sequencer.sv
`include "sd_dat_settings.svh"

module dat_block_sequencer (
    input  logic                   sd_clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  logic [7:0]             in_data,
    output logic                   credit_return,
    output sd_dat_pkg::dat_phase_e phase,
    output logic                   step,
    output sd_dat_pkg::lane_bus_t  lane_bits
);
    import sd_dat_pkg::*;

    localparam int PTR_W    = $clog2(`SD_FIFO_DEPTH);
    localparam int CNT_W    = $clog2(2 * `SD_BLOCK_BYTES);
    localparam int NIB_LAST = 2 * `SD_BLOCK_BYTES - 1;

    // ==================================================
    // Byte FIFO
    // ==================================================
    logic [7:0]     fifo_mem [`SD_FIFO_DEPTH];
    logic [PTR_W:0] wr_ptr;     // Extra bit tells full from empty
    logic [PTR_W:0] rd_ptr;
    logic           fifo_empty;
    logic           pop;
    logic [7:0]     head;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign head       = fifo_mem[rd_ptr[PTR_W-1:0]];

    // Host holds a credit for every write, so no full check
    always_ff @(posedge sd_clk) begin
        if (in_valid) begin
            fifo_mem[wr_ptr[PTR_W-1:0]] <= in_data;
        end
    end

    always_ff @(posedge sd_clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            credit_return <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            credit_return <= pop;   // One credit back per byte popped
        end
    end

    // ==================================================
    // Phase walker
    // ==================================================
    dat_phase_e       state;
    logic [CNT_W-1:0] cnt;          // Nibbles, CRC bits or gap cycles
    logic             low_nibble;

    // In data phase the count LSB selects the nibble
    assign low_nibble = cnt[0];
    assign lane_bits  = low_nibble ? head[3:0] : head[7:4];
    assign pop        = step && (state == PH_DATA) && low_nibble;

    // Stall decision lives here only
    always_comb begin
        phase = state;
        step  = 1'b0;
        case (state)
            PH_IDLE: begin
                if (!fifo_empty) begin
                    phase = PH_START;   // Start nibble goes out right away
                    step  = 1'b1;
                end
            end
            PH_DATA: step = !fifo_empty;            // Starved FIFO holds the lines
            PH_CRC, PH_END, PH_GAP: step = 1'b1;    // Never stall
            default: step = 1'b0;
        endcase
    end

    always_ff @(posedge sd_clk) begin
        if (rst) begin
            state <= PH_IDLE;
            cnt   <= '0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
            case (phase)
                PH_START: begin
                    state <= PH_DATA;
                    cnt   <= '0;
                end
                PH_DATA: begin
                    if (cnt == CNT_W'(NIB_LAST)) begin
                        state <= PH_CRC;
                        cnt   <= '0;
                    end
                end
                PH_CRC: begin
                    if (cnt == CNT_W'(`SD_CRC_BITS - 1)) begin
                        state <= PH_END;
                        cnt   <= '0;
                    end
                end
                PH_END: begin
                    state <= PH_GAP;
                    cnt   <= '0;
                end
                PH_GAP: begin
                    if (cnt == CNT_W'(`SD_GAP_CYCLES - 1)) begin
                        state <= PH_IDLE;
                        cnt   <= '0;
                    end
                end
                default: state <= PH_IDLE;
            endcase
        end
    end

endmodule

//--- dat_bus_driver.sv
module dat_bus_driver (
    input  logic                   sd_clk,
    input  logic                   rst,
    input  sd_dat_pkg::dat_phase_e phase,
    input  logic                   step,
    input  sd_dat_pkg::lane_bus_t  lanes,
    output sd_dat_pkg::nibble_t    sd_dat,
    output logic                   sd_dat_oe,
    output logic                   sd_dat_valid,
    output logic                   block_done
);
    import sd_dat_pkg::*;

    dat_phase_e phase_d;    // Lines up with the lane registers
    logic       step_d;

    always_ff @(posedge sd_clk) begin
        if (rst) begin
            phase_d <= PH_IDLE;
            step_d  <= 1'b0;
        end else begin
            phase_d <= phase;
            step_d  <= step;
        end
    end

    // ==================================================
    // Pin registers
    // ==================================================
    always_ff @(posedge sd_clk) begin
        if (rst) begin
            sd_dat       <= NIB_RELEASED;
            sd_dat_oe    <= 1'b0;
            sd_dat_valid <= 1'b0;
            block_done   <= 1'b0;
        end else begin
            sd_dat_valid <= step_d;
            block_done   <= step_d && (phase_d == PH_END);
            // No step means a stall, so the lines keep their value
            if (step_d) begin
                case (phase_d)
                    PH_START: begin
                        sd_dat    <= NIB_START;
                        sd_dat_oe <= 1'b1;
                    end
                    PH_DATA, PH_CRC: begin
                        sd_dat    <= lanes;
                        sd_dat_oe <= 1'b1;
                    end
                    PH_END: begin
                        sd_dat    <= NIB_END;
                        sd_dat_oe <= 1'b1;
                    end
                    default: begin
                        sd_dat    <= NIB_RELEASED;  // Gap
                        sd_dat_oe <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

//--- dat_lane_crc.sv
`include "sd_dat_settings.svh"

module dat_lane_crc (
    input  logic                   sd_clk,
    input  logic                   rst,
    input  sd_dat_pkg::dat_phase_e phase,
    input  logic                   step,
    input  logic                   bit_in,
    output logic                   lane_bit
);
    import sd_dat_pkg::*;

    // CRC16 x^16+x^12+x^5+1, initial value zero, MSB first
    localparam logic [`SD_CRC_BITS-1:0] CRC_POLY = 16'h1021;

    logic [`SD_CRC_BITS-1:0] crc;
    logic [`SD_CRC_BITS-1:0] crc_next;
    logic                    feedback;

    assign feedback = crc[`SD_CRC_BITS-1] ^ bit_in;
    assign crc_next = {crc[`SD_CRC_BITS-2:0], 1'b0} ^ (feedback ? CRC_POLY : '0);

    // ==================================================
    // Lane bit register
    // ==================================================
    always_ff @(posedge sd_clk) begin
        if (step) begin
            if (phase == PH_DATA) begin
                lane_bit <= bit_in;
            end else if (phase == PH_CRC) begin
                lane_bit <= crc[`SD_CRC_BITS-1];    // Remainder goes out MSB first
            end
        end
    end

    // ==================================================
    // CRC register
    // ==================================================
    always_ff @(posedge sd_clk) begin
        if (rst) begin
            crc <= '0;
        end else if (step) begin
            case (phase)
                PH_DATA: crc <= crc_next;
                PH_CRC:  crc <= {crc[`SD_CRC_BITS-2:0], 1'b0};
                PH_END:  crc <= '0;     // Ready for next block
                default: crc <= crc;
            endcase
        end
    end

endmodule

//--- sd_dat_pkg.sv
`include "sd_dat_settings.svh"

package sd_dat_pkg;

    // ==================================================
    // Block phases
    // ==================================================
    typedef enum logic [2:0] {
        PH_IDLE  = 3'd0,  // Waiting for the first byte
        PH_START = 3'd1,  // Start nibble of zeros
        PH_DATA  = 3'd2,  // Payload, high nibble first
        PH_CRC   = 3'd3,  // One CRC16 bit per lane per step
        PH_END   = 3'd4,  // End nibble of ones
        PH_GAP   = 3'd5   // Lines released
    } dat_phase_e;

    // ==================================================
    // Bus types
    // ==================================================
    // One wide-bus transfer unit on DAT[3:0]
    typedef logic [3:0] nibble_t;

    // One bit per DAT lane
    typedef logic [`SD_LANES-1:0] lane_bus_t;

    // Fixed nibbles framing a block
    localparam nibble_t NIB_START    = 4'b0000;
    localparam nibble_t NIB_END      = 4'b1111;

    // Pull-ups hold the lines high when nobody drives them
    localparam nibble_t NIB_RELEASED = 4'b1111;

endpackage

//--- sd_dat_settings.svh
`ifndef SD_DAT_SETTINGS_SVH
`define SD_DAT_SETTINGS_SVH

// Payload bytes per read block
`define SD_BLOCK_BYTES 512

// Byte FIFO slots, also the host's credit count after reset
`define SD_FIFO_DEPTH 8

// CRC16 length per lane
`define SD_CRC_BITS 16

// Released bit times between blocks
`define SD_GAP_CYCLES 2

// Wide-bus DAT lanes
`define SD_LANES 4

`endif

//--- sd_read_properties.sv
`include "sd_dat_settings.svh"

module sd_read_properties (
    input logic                sd_clk,
    input logic                rst,
    input logic                in_valid,
    input logic [7:0]          in_data,
    input logic                credit_return,
    input sd_dat_pkg::nibble_t sd_dat,
    input logic                sd_dat_oe,
    input logic                sd_dat_valid,
    input logic                block_done
);
    import sd_dat_pkg::*;

    // Frame positions counted in valid bit times
    localparam int DATA_NIBS = 2 * `SD_BLOCK_BYTES;
    localparam int CRC_FIRST = 1 + DATA_NIBS;
    localparam int END_POS   = CRC_FIRST + `SD_CRC_BITS;
    localparam int FRAME_LEN = END_POS + 1 + `SD_GAP_CYCLES;
    localparam int RING      = 256;

    int fail_count = 0;

    // ==================================================
    // Reference model
    // ==================================================
    logic [7:0]  byte_mem [RING];      // Bytes sent but not yet seen on the pins
    logic [15:0] ref_crc [`SD_LANES];
    int          wr_cnt;
    int          rd_cnt;
    int          held;                 // Sent minus credits returned
    int          pos;                  // Next valid bit time within the frame
    int          pending;
    logic        seen_byte;
    logic        is_data;
    logic        is_crc;
    logic [7:0]  head;
    nibble_t     exp_nib;

    // CRC16 x^16+x^12+x^5+1, zero start, data bit enters at the MSB end
    function automatic logic [15:0] crc16_bit(input logic [15:0] crc, input logic b);
        logic        fb;
        logic [15:0] nxt;
        fb       = crc[15] ^ b;
        nxt      = {crc[14:0], fb};
        nxt[5]   = crc[4] ^ fb;
        nxt[12]  = crc[11] ^ fb;
        return nxt;
    endfunction

    always_comb begin
        pending = wr_cnt - rd_cnt;
        is_data = (pos >= 1) && (pos <= DATA_NIBS);
        is_crc  = (pos >= CRC_FIRST) && (pos < END_POS);
        head    = byte_mem[rd_cnt % RING];
        exp_nib = 4'b1111;
        if (pos == 0) begin
            exp_nib = 4'b0000;
        end else if (is_data) begin
            exp_nib = (pos % 2 == 1) ? head[7:4] : head[3:0];   // High nibble first
        end else if (is_crc) begin
            for (int i = 0; i < `SD_LANES; i++) begin
                exp_nib[i] = ref_crc[i][15 - (pos - CRC_FIRST)];
            end
        end
    end

    always_ff @(posedge sd_clk) begin
        if (rst) begin
            wr_cnt    <= 0;
            rd_cnt    <= 0;
            held      <= 0;
            pos       <= 0;
            seen_byte <= 1'b0;
            for (int i = 0; i < `SD_LANES; i++) begin
                ref_crc[i] <= '0;
            end
        end else begin
            if (in_valid) begin
                byte_mem[wr_cnt % RING] <= in_data;
                wr_cnt    <= wr_cnt + 1;
                seen_byte <= 1'b1;
            end
            held <= held + int'(in_valid) - int'(credit_return);
            if (sd_dat_valid) begin
                pos <= (pos == FRAME_LEN - 1) ? 0 : pos + 1;
                for (int i = 0; i < `SD_LANES; i++) begin
                    if (pos == 0) begin
                        ref_crc[i] <= '0;
                    end else if (is_data) begin
                        ref_crc[i] <= crc16_bit(ref_crc[i], exp_nib[i]);
                    end
                end
                if (is_data && (pos % 2 == 0)) begin
                    rd_cnt <= rd_cnt + 1;   // Low nibble retires the byte
                end
            end
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    property holds(bit ok);
        @(posedge sd_clk) disable iff (rst) ok;
    endproperty

    a_quiet: assert property (holds(seen_byte ||
            !(sd_dat_oe || sd_dat_valid || block_done || credit_return))) else begin
        fail_count++;
        $error("mismatch at %0t: output active before the first byte", $time);
    end

    a_nibble: assert property (holds(!sd_dat_valid || pos > END_POS || sd_dat == exp_nib))
    else begin
        fail_count++;
        $error("mismatch at %0t: frame position %0d shows %h, expected %h",
               $time, $sampled(pos), $sampled(sd_dat), $sampled(exp_nib));
    end

    // Driven from start nibble through end nibble, released otherwise
    a_oe: assert property (holds(sd_dat_oe ==
            ((pos >= 1 && pos <= END_POS) || (pos == 0 && sd_dat_valid)))) else begin
        fail_count++;
        $error("mismatch at %0t: sd_dat_oe is %b at frame position %0d",
               $time, $sampled(sd_dat_oe), $sampled(pos));
    end

    a_done: assert property (holds(block_done == (sd_dat_valid && pos == END_POS))) else begin
        fail_count++;
        $error("mismatch at %0t: block_done apart from the end nibble", $time);
    end

    a_no_repeat: assert property (holds(!(sd_dat_valid && is_data) || pending > 0)) else begin
        fail_count++;
        $error("mismatch at %0t: data nibble with no byte left to send", $time);
    end

    a_credit: assert property (holds(held >= 0 && held <= `SD_FIFO_DEPTH)) else begin
        fail_count++;
        $error("mismatch at %0t: %0d bytes held in the DUT", $time, $sampled(held));
    end

    a_returned: assert property (holds(!block_done || held == pending)) else begin
        fail_count++;
        $error("mismatch at %0t: credits for the block not all returned", $time);
    end

endmodule

bind sd_read_top sd_read_properties i_props (.*);

//--- sd_read_top.sv
`include "sd_dat_settings.svh"

module sd_read_top (
    input  logic                sd_clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic [7:0]          in_data,
    output logic                credit_return,
    output sd_dat_pkg::nibble_t sd_dat,
    output logic                sd_dat_oe,
    output logic                sd_dat_valid,
    output logic                block_done
);
    import sd_dat_pkg::*;

    dat_phase_e phase;
    logic       step;
    lane_bus_t  lane_bits;  // Nibble into the lanes
    lane_bus_t  lanes;      // Registered lane outputs

    // ==================================================
    // Block sequencer
    // ==================================================
    dat_block_sequencer i_sequencer (
        .sd_clk        (sd_clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .credit_return (credit_return),
        .phase         (phase),
        .step          (step),
        .lane_bits     (lane_bits)
    );

    // One CRC16 per DAT lane
    for (genvar i = 0; i < `SD_LANES; i++) begin : g_lane
        dat_lane_crc i_lane (
            .sd_clk   (sd_clk),
            .rst      (rst),
            .phase    (phase),
            .step     (step),
            .bit_in   (lane_bits[i]),
            .lane_bit (lanes[i])
        );
    end

    dat_bus_driver i_driver (
        .sd_clk       (sd_clk),
        .rst          (rst),
        .phase        (phase),
        .step         (step),
        .lanes        (lanes),
        .sd_dat       (sd_dat),
        .sd_dat_oe    (sd_dat_oe),
        .sd_dat_valid (sd_dat_valid),
        .block_done   (block_done)
    );

endmodule

//--- tb_sd_read.sv
`include "sd_dat_settings.svh"

module tb_sd_read;
    import sd_dat_pkg::*;

    localparam int NUM_BLOCKS     = 3;
    localparam int TIMEOUT_CYCLES = NUM_BLOCKS * (`SD_BLOCK_BYTES * 2 + 19) * 8;

    logic       sd_clk = 1'b0;
    logic       rst;
    logic       in_valid;
    logic [7:0] in_data;
    logic       credit_return;
    nibble_t    sd_dat;
    logic       sd_dat_oe;
    logic       sd_dat_valid;
    logic       block_done;

    int sent     = 0;
    int returned = 0;
    int blocks   = 0;
    int cycles   = 0;

    sd_read_top i_dut (.*);

    always #2 sd_clk = ~sd_clk;

    // Host bookkeeping on the falling edge, where outputs are settled
    always @(negedge sd_clk) begin
        if (!rst) begin
            returned <= returned + int'(credit_return);
            blocks   <= blocks + int'(block_done);
        end
    end

    // ==================================================
    // Watchdogs
    // ==================================================
    always @(posedge sd_clk) begin
        cycles <= cycles + 1;
        if (i_dut.i_props.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "A DUT check failed, see the error above");
        end else if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timed out after %0d cycles with %0d of %0d blocks done",
                     cycles, blocks, NUM_BLOCKS);
            $display("Test failed");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge sd_clk);
            #1;
        end
    endtask

    // One byte per credit, waits while all credits are spent
    task automatic send_byte(input logic [7:0] data);
        while (sent - returned >= `SD_FIFO_DEPTH) begin
            idle(1);
        end
        in_valid = 1'b1;
        in_data  = data;
        sent++;
        idle(1);
        in_valid = 1'b0;
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_data  = 8'h00;
        void'($urandom(32'h18ba99e9));
        repeat (10) @(posedge sd_clk);
        #1;
        rst = 1'b0;
        idle(20);   // Outputs must stay quiet here
        for (int n = 0; n < NUM_BLOCKS * `SD_BLOCK_BYTES; n++) begin
            if ($urandom_range(63) == 0) begin
                idle($urandom_range(40, 20));   // Long enough to drain the FIFO
            end else if ($urandom_range(3) == 0) begin
                idle(1);
            end
            send_byte(8'($urandom));
        end
        wait (blocks == NUM_BLOCKS);
        idle(4);
        if (i_dut.i_props.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "A DUT check failed near the end of the run");
        end
    end

endmodule

//--- verilog.f
+incdir+.
sd_dat_pkg.sv
dat_block_sequencer.sv
dat_lane_crc.sv
dat_bus_driver.sv
sd_read_top.sv
sd_read_properties.sv
tb_sd_read.sv
